//--- Makefile
# Verilator build and run for the clearing PRNG testbench

TOP := tb_clearing_prng
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- design/clearing_lfsr.sv
// Clearing LFSR core
// 64-bit Galois XOR LFSR with seed loading; the output share is the
// state passed through permutation, PRINCE S-box layer and permutation

`timescale 1ns/1ps

module clearing_lfsr (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  lfsr_ctrl_if.core            ctrl,
  output prng_pkg::prng_word_t share0_o
);
  import prng_pkg::*;

  localparam int unsigned NUM_NIBBLES = PRNG_WIDTH / 4;

  prng_word_t state_q;
  prng_word_t state_step;
  prng_word_t perm_in;
  prng_word_t sbox_out;

  // Galois step
  // Shift right and fold in the tap mask if a one falls out
  always_comb begin
    state_step = (state_q >> 1) ^ ({PRNG_WIDTH{state_q[0]}} & LFSR_POLY);
  end

  // State register
  // A seed load wins over a step in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LFSR_SEED_DEFAULT;
    end else if (ctrl.seed_en) begin
      state_q <= ctrl.seed;
    end else if (ctrl.step_en) begin
      state_q <= state_step;
    end
  end

  assign ctrl.state = state_q;

  // First permutation spreads neighbouring state bits
  // over different S-box inputs
  always_comb begin
    perm_in = state_perm(state_q);
  end

  // Nonlinear layer of one PRINCE S-box per nibble
  always_comb begin
    sbox_out = '0;
    for (int unsigned k = 0; k < NUM_NIBBLES; k++) begin
      sbox_out[4*k +: 4] = PRINCE_SBOX[perm_in[4*k +: 4]];
    end
  end

  // Same permutation again on the way out
  // Output follows the registered state without extra latency
  always_comb begin
    share0_o = state_perm(sbox_out);
  end

  // All-zero state is a lockup, which only a bad seed can cause
  a_state_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ctrl.state != '0
  ) else $error("LFSR state is zero");

endmodule

//--- design/clearing_prng.sv
// Clearing PRNG controller
// Arbitrates reseed against data requests, drives the LFSR controls
// and derives the second share from the first

`timescale 1ns/1ps

module clearing_prng (
  input  logic                 reseed_req_i,
  input  logic                 data_req_i,
  input  logic                 seed_valid_i,
  input  prng_pkg::prng_word_t seed_i,
  input  prng_pkg::prng_word_t share0_i,
  output logic                 data_ack_o,
  output logic                 reseed_ack_o,
  output prng_pkg::prng_word_t share1_o,
  lfsr_ctrl_if.ctrl            ctrl
);
  import prng_pkg::*;

  // Reseed has priority
  // Data is only served while no reseed is pending
  assign data_ack_o = data_req_i & ~reseed_req_i;

  // Every acknowledged data cycle consumes one LFSR state
  // so the next ack sees the following state
  assign ctrl.step_en = data_ack_o;

  // Complete seed loads at the closing edge of this cycle
  assign ctrl.seed_en = seed_valid_i;
  assign ctrl.seed    = seed_i;

  // Reseed is done in the cycle of the second entropy transfer
  // New state is visible from the next cycle on
  assign reseed_ack_o = seed_valid_i;

  // Second share is a fixed bit shuffle of the first
  always_comb begin
    share1_o = share_perm(share0_i);
  end

  // Both acks together would mean a step and a load in one cycle
  // seed_valid_i comes from the buffer, so this spans both modules
  always_comb begin
    a_acks_exclusive: assert final (!(data_ack_o && reseed_ack_o))
      else $error("data_ack_o and reseed_ack_o high together");
  end

endmodule

//--- design/clearing_prng_top.sv
// Clearing PRNG top level
// Two-share pseudo-random data for register wipe, with reseeding
// from 32-bit entropy words

`timescale 1ns/1ps

module clearing_prng_top (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Consumer side
  input  logic        data_req_i,
  output logic        data_ack_o,
  output logic [63:0] data_o0,
  output logic [63:0] data_o1,
  input  logic        reseed_req_i,
  output logic        reseed_ack_o,
  // Entropy source side
  output logic        entropy_req_o,
  input  logic        entropy_ack_i,
  input  logic [31:0] entropy_i
);
  import prng_pkg::*;

  logic       seed_valid;
  prng_word_t seed;
  prng_word_t shares [NUM_SHARES];

  lfsr_ctrl_if u_lfsr_ctrl ();

  entropy_buffer u_entropy_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reseed_req_i  (reseed_req_i),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i),
    .entropy_req_o (entropy_req_o),
    .seed_valid_o  (seed_valid),
    .seed_o        (seed)
  );

  clearing_prng u_clearing_prng (
    .reseed_req_i (reseed_req_i),
    .data_req_i   (data_req_i),
    .seed_valid_i (seed_valid),
    .seed_i       (seed),
    .share0_i     (shares[0]),
    .data_ack_o   (data_ack_o),
    .reseed_ack_o (reseed_ack_o),
    .share1_o     (shares[1]),
    .ctrl         (u_lfsr_ctrl.ctrl)
  );

  clearing_lfsr u_clearing_lfsr (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .ctrl     (u_lfsr_ctrl.core),
    .share0_o (shares[0])
  );

  // Shares out to the flat consumer ports
  assign data_o0 = shares[0];
  assign data_o1 = shares[1];

endmodule

//--- design/entropy_buffer.sv
// Entropy buffer
// Gathers two 32-bit entropy words into one 64-bit LFSR seed
// over the req/ack handshake with the entropy source

`timescale 1ns/1ps

module entropy_buffer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   reseed_req_i,
  input  logic                   entropy_ack_i,
  input  prng_pkg::entropy_word_t entropy_i,
  output logic                   entropy_req_o,
  output logic                   seed_valid_o,
  output prng_pkg::prng_word_t   seed_o
);
  import prng_pkg::*;

  entropy_word_t buffer_q;
  logic          buffer_valid_q;
  logic          xfer;

  // Keep requesting for as long as the consumer wants a reseed
  // The request drops once the consumer sees its ack
  assign entropy_req_o = reseed_req_i;

  // One word moves in every cycle with req and ack both high
  assign xfer = entropy_req_o & entropy_ack_i;

  // Valid flag flips on every transfer
  // Set after the first word, cleared at the edge of the second
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buffer_valid_q <= 1'b0;
    end else if (xfer) begin
      buffer_valid_q <= ~buffer_valid_q;
    end
  end

  // Capture only the first word of a pair
  always_ff @(posedge clk_i) begin
    if (xfer && !buffer_valid_q) begin
      buffer_q <= entropy_i;
    end
  end

  // Seed is complete in the cycle of the second transfer
  // Buffered word goes to the upper half
  assign seed_valid_o = xfer & buffer_valid_q;
  assign seed_o       = {buffer_q, entropy_i};

  // Source may only ack a pending request
  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    entropy_ack_i |-> entropy_req_o
  ) else $error("entropy_ack_i high without entropy_req_o");

endmodule

//--- design/lfsr_ctrl_if.sv
// LFSR control interface
// Carries seed load, step enable and the LFSR state between the
// request controller and the LFSR core

`timescale 1ns/1ps

interface lfsr_ctrl_if;
  import prng_pkg::*;

  // Load strobe and value
  // Loading wins over stepping
  logic       seed_en;
  prng_word_t seed;
  // Advance one Galois step at the next edge
  logic       step_en;
  // Current LFSR state as held by the core
  prng_word_t state;

  // Controller side
  modport ctrl (
    output seed_en,
    output seed,
    output step_en
  );

  // LFSR side
  modport core (
    input  seed_en,
    input  seed,
    input  step_en,
    output state
  );

endinterface

//--- design/prng_pkg.sv
// Clearing PRNG package
// Widths, LFSR constants, bit permutations and the PRINCE S-box
// shared by the register-wipe pseudo-random generator

package prng_pkg;

  // Datapath widths
  // Entropy arrives in half-width words
  localparam int unsigned PRNG_WIDTH    = 64;
  localparam int unsigned ENTROPY_WIDTH = PRNG_WIDTH / 2;
  localparam int unsigned NUM_SHARES    = 2;

  typedef logic [PRNG_WIDTH-1:0]    prng_word_t;
  typedef logic [ENTROPY_WIDTH-1:0] entropy_word_t;

  // Galois tap mask for taps 64, 63, 61, 60
  // XORed into the shifted state when the outgoing LSB is set
  localparam prng_word_t LFSR_POLY = 64'hd800_0000_0000_0000;

  // Reset seed must be nonzero or the LFSR locks up
  localparam prng_word_t LFSR_SEED_DEFAULT = 64'h5a3c_96e1_0f7b_d248;

  // Multipliers of the two index permutations
  // Both are odd, so i -> m*i mod 64 is a bijection
  localparam int unsigned STATE_PERM_MULT = 13;
  localparam int unsigned SHARE_PERM_MULT = 29;

  // PRINCE 4-bit S-box
  // Entry k is the image of nibble value k
  localparam logic [3:0] PRINCE_SBOX [16] = '{
    4'hb, 4'hf, 4'h3, 4'h2, 4'ha, 4'hc, 4'h9, 4'h1,
    4'h6, 4'h7, 4'h8, 4'h0, 4'he, 4'h5, 4'hd, 4'h4
  };

  // Output bit i takes input bit (mult * i) mod width
  function automatic prng_word_t mult_perm(prng_word_t word_in, int unsigned mult);
    prng_word_t word_out;
    word_out = '0;
    for (int unsigned i = 0; i < PRNG_WIDTH; i++) begin
      word_out[i] = word_in[(mult * i) % PRNG_WIDTH];
    end
    return word_out;
  endfunction

  // Permutation around the S-box layer, applied before and after
  function automatic prng_word_t state_perm(prng_word_t word_in);
    return mult_perm(word_in, STATE_PERM_MULT);
  endfunction

  // Second share is the first one under this fixed permutation
  function automatic prng_word_t share_perm(prng_word_t word_in);
    return mult_perm(word_in, SHARE_PERM_MULT);
  endfunction

endpackage

//--- list.f
design/prng_pkg.sv
design/lfsr_ctrl_if.sv
design/entropy_buffer.sv
design/clearing_lfsr.sv
design/clearing_prng.sv
design/clearing_prng_top.sv
verification/tb_clearing_prng.sv

//--- verification/prng_tests.txt
# Columns: RESET name exp_entropy_req exp_data_ack exp_reseed_ack
#          DATA name exp_lfsr_state (hex, shares follow from it)
#          RESEED name word0 word1 max_stall_cycles (0 means no stall)
RESET reset_idle 0 0 0
DATA first_after_reset 5a3c96e10f7bd248
DATA back_to_back_1 2d1e4b7087bde924
DATA back_to_back_2 168f25b843def492
DATA back_to_back_3 0b4792dc21ef7a49
DATA back_to_back_4 dda3c96e10f7bd24
RESEED reseed_no_stall 87654321 0fedcba9 0
DATA first_after_reseed 876543210fedcba9
RESEED reseed_with_stall 87654321 0fedcba9 6
DATA first_after_stall 876543210fedcba9
DATA seq_after_reseed_1 9bb2a19087f6e5d4
DATA seq_after_reseed_2 4dd950c843fb72ea

//--- verification/tb_clearing_prng.sv
// Clearing PRNG testbench
// Reads operations from the tests file, drives requests and entropy,
// checks shares against a reference model and reports per test

`timescale 1ns/1ps

module tb_clearing_prng;

  localparam int MAX_WAIT = 50;

  logic        clk_i;
  logic        rst_ni;
  logic        data_req_i;
  logic        data_ack_o;
  logic [63:0] data_o0;
  logic [63:0] data_o1;
  logic        reseed_req_i;
  logic        reseed_ack_o;
  logic        entropy_req_o;
  logic        entropy_ack_i;
  logic [31:0] entropy_i;

  int          test_errors;
  int          pass_count;
  int          fail_count;
  bit          timed_out;
  logic [31:0] lcg_state;

  clearing_prng_top UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_i),
    .data_ack_o    (data_ack_o),
    .data_o0       (data_o0),
    .data_o1       (data_o1),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Stall lengths for the entropy source
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference bit permutation
  // Bit i of the result takes bit (mult*i) mod 64
  function automatic logic [63:0] permute_bits(logic [63:0] w, int mult);
    logic [63:0] r;
    for (int i = 0; i < 64; i++) begin
      r[i] = w[(mult * i) % 64];
    end
    return r;
  endfunction

  function automatic logic [3:0] prince_sbox(logic [3:0] x);
    logic [63:0] table_bits;
    table_bits = 64'h4d5e_0876_19ca_23fb;
    return table_bits[4*x +: 4];
  endfunction

  function automatic logic [63:0] model_share0(logic [63:0] state);
    logic [63:0] p;
    logic [63:0] s;
    p = permute_bits(state, 13);
    for (int k = 0; k < 16; k++) begin
      s[4*k +: 4] = prince_sbox(p[4*k +: 4]);
    end
    return permute_bits(s, 13);
  endfunction

  task automatic check_value(string name, string what, logic [63:0] exp, logic [63:0] act);
    assert (exp === act) else begin
      $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic finish_test(string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d errors", name, test_errors);
    end
  endtask

  // Both waits sample at the falling edge where outputs are settled
  // and return how many extra cycles the response took
  task automatic wait_data_ack(string name, output int cycles);
    int n;
    n = 0;
    @(negedge clk_i);
    while (data_ack_o !== 1'b1 && n < MAX_WAIT) begin
      @(negedge clk_i);
      n++;
    end
    cycles = n;
    if (data_ack_o !== 1'b1) begin
      $display("%s: data request was not acknowledged within %0d cycles", name, MAX_WAIT);
      timed_out = 1'b1;
      test_errors++;
    end
  endtask

  task automatic wait_entropy_req(string name, output int cycles);
    int n;
    n = 0;
    @(negedge clk_i);
    while (entropy_req_o !== 1'b1 && n < MAX_WAIT) begin
      @(negedge clk_i);
      n++;
    end
    cycles = n;
    if (entropy_req_o !== 1'b1) begin
      $display("%s: entropy request never went high within %0d cycles", name, MAX_WAIT);
      timed_out = 1'b1;
      test_errors++;
    end
  endtask

  task automatic check_reset_idle(string name, logic er, logic da, logic ra);
    @(posedge clk_i);
    #2;
    data_req_i   = 1'b0;
    reseed_req_i = 1'b0;
    @(negedge clk_i);
    check_value(name, "entropy_req_o", 64'(er), 64'(entropy_req_o));
    check_value(name, "data_ack_o", 64'(da), 64'(data_ack_o));
    check_value(name, "reseed_ack_o", 64'(ra), 64'(reseed_ack_o));
  endtask

  // Request stays high, so consecutive DATA lines are back to back
  task automatic request_data(string name, logic [63:0] state);
    logic [63:0] exp0;
    int          ack_cycles;
    exp0 = model_share0(state);
    @(posedge clk_i);
    #2;
    data_req_i = 1'b1;
    wait_data_ack(name, ack_cycles);
    if (!timed_out) begin
      // Ack is combinational in the request cycle
      check_value(name, "data_ack_o latency", 64'd0, 64'(ack_cycles));
      check_value(name, "data_o0", exp0, data_o0);
      check_value(name, "data_o1", permute_bits(exp0, 29), data_o1);
    end
  endtask

  // Data request is held pending to check that reseed wins
  task automatic reseed_from_source(string name, logic [31:0] w0, logic [31:0] w1,
                                    int max_stall);
    logic [31:0] words [2];
    int          stall;
    int          req_cycles;
    words[0] = w0;
    words[1] = w1;
    @(posedge clk_i);
    #2;
    reseed_req_i  = 1'b1;
    data_req_i    = 1'b1;
    entropy_ack_i = 1'b0;
    wait_entropy_req(name, req_cycles);
    if (!timed_out) begin
      check_value(name, "entropy_req_o latency", 64'd0, 64'(req_cycles));
    end
    check_value(name, "data_ack_o", 64'd0, 64'(data_ack_o));
    for (int w = 0; w < 2 && !timed_out; w++) begin
      stall = (max_stall > 0) ? int'((next_random() >> 8) % (max_stall + 1)) : 0;
      repeat (stall) begin
        @(posedge clk_i);
        #2;
        entropy_ack_i = 1'b0;
        @(negedge clk_i);
        check_value(name, "entropy_req_o", 64'd1, 64'(entropy_req_o));
        check_value(name, "data_ack_o", 64'd0, 64'(data_ack_o));
        check_value(name, "reseed_ack_o", 64'd0, 64'(reseed_ack_o));
      end
      @(posedge clk_i);
      #2;
      entropy_ack_i = 1'b1;
      entropy_i     = words[w];
      @(negedge clk_i);
      check_value(name, "data_ack_o", 64'd0, 64'(data_ack_o));
      // Ack pulses only with the second word
      check_value(name, "reseed_ack_o", 64'(w == 1), 64'(reseed_ack_o));
    end
    @(posedge clk_i);
    #2;
    entropy_ack_i = 1'b0;
    entropy_i     = '0;
    reseed_req_i  = 1'b0;
    data_req_i    = 1'b0;
  endtask

  initial begin
    int          fd;
    int          r;
    string       op;
    string       name;
    string       line;
    logic [63:0] state;
    logic [31:0] w0;
    logic [31:0] w1;
    int          stall;
    logic        er;
    logic        da;
    logic        ra;
    rst_ni        = 1'b0;
    data_req_i    = 1'b0;
    reseed_req_i  = 1'b0;
    entropy_ack_i = 1'b0;
    entropy_i     = '0;
    pass_count    = 0;
    fail_count    = 0;
    timed_out     = 1'b0;
    lcg_state     = 32'h14fe;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    fd = $fopen("verification/prng_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the tests file verification/prng_tests.txt");
      fail_count++;
    end else begin
      while (!timed_out && $fscanf(fd, "%s", op) == 1) begin
        test_errors = 0;
        if (op.substr(0, 0) == "#") begin
          r = $fgets(line, fd);
        end else if (op == "RESET") begin
          r = $fscanf(fd, "%s %b %b %b", name, er, da, ra);
          check_reset_idle(name, er, da, ra);
          finish_test(name);
        end else if (op == "DATA") begin
          r = $fscanf(fd, "%s %h", name, state);
          request_data(name, state);
          finish_test(name);
        end else if (op == "RESEED") begin
          r = $fscanf(fd, "%s %h %h %d", name, w0, w1, stall);
          reseed_from_source(name, w0, w1, stall);
          finish_test(name);
        end else begin
          $display("Unknown operation %s in the tests file", op);
          fail_count++;
        end
      end
      $fclose(fd);
    end
    $display("Tests passed %0d, tests failed %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
